// File: logic/qla_settings.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build-time settings for the motor controller register map
// QLA_NUM_MOTORS must stay below 16, the block field is 4 bits
// QLA_WDOG_TICK must be 2 or more
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef QLA_SETTINGS_SVH
`define QLA_SETTINGS_SVH

`define QLA_NUM_MOTORS  4       // motor channels, blocks 1..N
`define QLA_ADDR_W      16      // register address width
`define QLA_DATA_W      32      // register data width
`define QLA_CMD_W       16      // current command width
`define QLA_POS_W       24      // encoder count, sign-extended on read
`define QLA_WDOG_TICK   16      // sysclk cycles per watchdog unit

// board block offsets (block 0)
`define QLA_OFS_STATUS  4'd0
`define QLA_OFS_TSTAMP  4'd1
`define QLA_OFS_WDOG    4'd2

// channel block offsets (blocks 1..N)
`define QLA_OFS_CMD     4'd0
`define QLA_OFS_AMP     4'd1
`define QLA_OFS_POS     4'd2

`endif

// File: logic/qla_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared bus and drive types for the controller
// field widths come from the settings header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "qla_settings.svh"

package qla_pkg;

    // one register access, valid is a single-cycle strobe
    typedef struct packed {
        logic                   valid;  // access strobe
        logic                   we;     // 1 = write, 0 = read
        logic [`QLA_ADDR_W-1:0] addr;   // [7:4] block, [3:0] offset
        logic [`QLA_DATA_W-1:0] wdata;  // write word
    } reg_req_t;

    // read answer of one block
    // zero when the address belongs to someone else, so answers can be ORed
    typedef struct packed {
        logic [`QLA_DATA_W-1:0] rdata;
    } reg_rsp_t;

    // drive output of one motor channel
    typedef struct packed {
        logic                  amp_en;  // amplifier enable
        logic [`QLA_CMD_W-1:0] cur_cmd; // current setpoint, raw dac code
    } motor_cmd_t;

endpackage

`default_nettype wire

// File: logic/reg_bus_slave.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic slave, full-word accesses only, no bursts
// write acks with 1 wait state, read with 2
// master must drop stb for a cycle after each ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "qla_settings.svh"

module reg_bus_slave (
    input  logic                   sysclk,
    input  logic                   arst_n,
    input  logic                   cyc,
    input  logic                   stb,
    input  logic                   we,
    input  logic [`QLA_ADDR_W-1:0] adr,
    input  logic [`QLA_DATA_W-1:0] dat_w,
    output logic [`QLA_DATA_W-1:0] dat_r,
    output logic                   ack,
    output qla_pkg::reg_req_t      req,
    input  qla_pkg::reg_rsp_t      rsp_chan,
    input  qla_pkg::reg_rsp_t      rsp_board
);

    typedef enum logic [1:0] {
        ST_IDLE,    // waiting for cyc && stb
        ST_ACCESS,  // request strobe out
        ST_RD_RET,  // read word registered, ack high
        ST_DONE     // wait for master to release stb
    } state_t;

    state_t                 state;
    logic                   cyc_open;
    logic                   req_valid;
    logic                   req_we;
    logic [`QLA_ADDR_W-1:0] req_addr;
    logic [`QLA_DATA_W-1:0] req_wdata;
    logic [`QLA_DATA_W-1:0] rd_mux;

    assign cyc_open = cyc && stb;
    assign rd_mux   = rsp_chan.rdata | rsp_board.rdata; // unselected blocks answer zero

    assign req = '{valid: req_valid, we: req_we, addr: req_addr, wdata: req_wdata};

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= ST_IDLE;
            req_valid <= 1'b0;
            req_we    <= 1'b0;
            ack       <= 1'b0;
        end else begin
            req_valid <= 1'b0;  // strobe lasts one cycle
            ack       <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cyc_open) begin
                        state     <= ST_ACCESS;
                        req_valid <= 1'b1;
                        req_we    <= we;
                        ack       <= we;    // write acks alongside the strobe
                    end
                end
                ST_ACCESS: begin
                    // blocks answer combinationally during this cycle
                    state <= req_we ? ST_DONE : ST_RD_RET;
                    ack   <= !req_we;
                end
                ST_RD_RET: state <= ST_DONE;
                ST_DONE: begin
                    if (!cyc_open) begin
                        state <= ST_IDLE;   // one request per bus cycle
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address, write word and read word are payload only
    always_ff @(posedge sysclk) begin
        if (state == ST_IDLE && cyc_open) begin
            req_addr  <= adr;
            req_wdata <= dat_w;
        end
        if (state == ST_ACCESS && !req_we) begin
            dat_r <= rd_mux;    // sampled at the end of the strobe cycle
        end
    end

endmodule

`default_nettype wire

// File: logic/quad_encoder.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// x4 quadrature decoder with wrapping position counter
// forward is phase a leading phase b
// inputs should idle at a=0, b=0 while arst_n is low
// a step reaches pos 3 cycles later, states must last 3+ cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "qla_settings.svh"

module quad_encoder (
    input  logic                  sysclk,
    input  logic                  arst_n,
    input  logic                  enc_a,
    input  logic                  enc_b,
    input  logic                  preset,
    input  logic [`QLA_POS_W-1:0] preset_val,
    output logic [`QLA_POS_W-1:0] pos
);

    logic [1:0] a_sync;     // [0] first stage, [1] second stage
    logic [1:0] b_sync;
    logic [1:0] ab_cur;     // {a, b} after sync
    logic [1:0] ab_prev;    // {a, b} one cycle earlier
    logic       step;
    logic       step_up;

    assign ab_cur = {a_sync[1], b_sync[1]};

    // exactly one phase moved, both moving is a lost state and is dropped
    assign step = ^(ab_cur ^ ab_prev);

    // gray order 00 -> 10 -> 11 -> 01 -> 00 counts up
    // new a differs from old b only on a forward step
    assign step_up = ab_cur[1] ^ ab_prev[0];

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            a_sync  <= 2'b00;
            b_sync  <= 2'b00;
            ab_prev <= 2'b00;
            pos     <= '0;
        end else begin
            a_sync  <= {a_sync[0], enc_a};
            b_sync  <= {b_sync[0], enc_b};
            ab_prev <= ab_cur;
            if (preset) begin
                pos <= preset_val;      // host load wins over a step
            end else if (step) begin
                if (step_up) begin
                    pos <= pos + 1'b1;  // wraps at the top
                end else begin
                    pos <= pos - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/motor_channels.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per-channel command, enable and encoder registers
// channel i answers at block i+1, address bits above 7 must be 0
// watchdog timeout holds every enable low
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "qla_settings.svh"

module motor_channels (
    input  logic                                      sysclk,
    input  logic                                      arst_n,
    input  qla_pkg::reg_req_t                         req,
    output qla_pkg::reg_rsp_t                         rsp,
    input  logic                                      wdog_timeout,
    input  logic [`QLA_NUM_MOTORS-1:0]                enc_a,
    input  logic [`QLA_NUM_MOTORS-1:0]                enc_b,
    output qla_pkg::motor_cmd_t [`QLA_NUM_MOTORS-1:0] motor_cmd
);

    localparam int N     = `QLA_NUM_MOTORS;
    localparam int EXT_W = `QLA_DATA_W - `QLA_POS_W;   // sign bits on position read

    logic [3:0]            blk;
    logic [3:0]            ofs;
    logic                  map_ok;
    logic                  wr;
    logic [N-1:0]          chan_sel;
    logic [N-1:0]          pos_preset;
    logic [`QLA_CMD_W-1:0] cur_cmd [N];
    logic                  amp_en  [N];
    logic [`QLA_POS_W-1:0] pos     [N];

    assign blk    = req.addr[7:4];
    assign ofs    = req.addr[3:0];
    assign map_ok = (req.addr[`QLA_ADDR_W-1:8] == '0);   // upper bits unmapped
    assign wr     = req.valid && req.we;

    for (genvar i = 0; i < N; i++) begin : g_chan
        assign chan_sel[i]   = map_ok && (blk == 4'(i + 1));
        assign pos_preset[i] = wr && chan_sel[i] && (ofs == `QLA_OFS_POS);

        quad_encoder u_quad_encoder (
            .sysclk     (sysclk),
            .arst_n     (arst_n),
            .enc_a      (enc_a[i]),
            .enc_b      (enc_b[i]),
            .preset     (pos_preset[i]),
            .preset_val (req.wdata[`QLA_POS_W-1:0]),
            .pos        (pos[i])
        );

        // timeout also masks the enable in the cycle before the register clears
        assign motor_cmd[i] = '{amp_en: amp_en[i] && !wdog_timeout, cur_cmd: cur_cmd[i]};
    end

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < N; i++) begin
                cur_cmd[i] <= '0;
                amp_en[i]  <= 1'b0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (wr && chan_sel[i] && ofs == `QLA_OFS_CMD) begin
                    cur_cmd[i] <= req.wdata[`QLA_CMD_W-1:0];
                end
                if (wdog_timeout) begin
                    amp_en[i] <= 1'b0;          // enable writes dropped meanwhile
                end else if (wr && chan_sel[i] && ofs == `QLA_OFS_AMP) begin
                    amp_en[i] <= req.wdata[0];
                end
            end
        end
    end

    // read mux, zero unless one of our channels is addressed
    always_comb begin
        rsp.rdata = '0;
        for (int i = 0; i < N; i++) begin
            if (chan_sel[i]) begin
                case (ofs)
                    `QLA_OFS_CMD: rsp.rdata = `QLA_DATA_W'(cur_cmd[i]);  // zero-extended
                    `QLA_OFS_AMP: rsp.rdata = `QLA_DATA_W'(amp_en[i]);
                    `QLA_OFS_POS: rsp.rdata = {{EXT_W{pos[i][`QLA_POS_W-1]}}, pos[i]};
                    default:      rsp.rdata = '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/board_status.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// board block 0: status, timestamp and watchdog period
// any write restarts the watchdog, period 0 disables it
// timeout stays set until status bit 8 is written with a one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "qla_settings.svh"

module board_status (
    input  logic              sysclk,
    input  logic              arst_n,
    input  qla_pkg::reg_req_t req,
    output qla_pkg::reg_rsp_t rsp,
    input  logic [3:0]        wenid,
    output logic              wdog_timeout
);

    localparam int PER_W  = 16;                         // period register width
    localparam int TICK_W = $clog2(`QLA_WDOG_TICK);

    logic [3:0]             board_id;
    logic [3:0]             ofs;
    logic                   brd_sel;
    logic                   wr;
    logic                   wdog_clr;
    logic                   counting;
    logic                   tick_wrap;
    logic                   expire;
    logic [`QLA_DATA_W-1:0] tstamp;
    logic [PER_W-1:0]       wdog_period;
    logic [PER_W-1:0]       per_cnt;    // elapsed period units
    logic [TICK_W-1:0]      tick_cnt;   // sysclk cycles inside one unit

    assign board_id = ~wenid;           // rotary switch is active low
    assign ofs      = req.addr[3:0];
    assign brd_sel  = (req.addr[`QLA_ADDR_W-1:4] == '0);
    assign wr       = req.valid && req.we;
    assign wdog_clr = wr && brd_sel && (ofs == `QLA_OFS_STATUS) && req.wdata[8];

    assign counting  = (wdog_period != '0) && !wdog_timeout;
    assign tick_wrap = (tick_cnt == TICK_W'(`QLA_WDOG_TICK - 1));
    // last tick of the last unit with no write this cycle
    assign expire    = counting && !wr && tick_wrap && (per_cnt == wdog_period - 1'b1);

    always_ff @(posedge sysclk or negedge arst_n) begin
        if (!arst_n) begin
            tstamp       <= '0;
            wdog_period  <= '0;
            tick_cnt     <= '0;
            per_cnt      <= '0;
            wdog_timeout <= 1'b0;
        end else begin
            tstamp <= tstamp + 1'b1;    // free-running, wraps
            if (wr && brd_sel && ofs == `QLA_OFS_WDOG) begin
                wdog_period <= req.wdata[PER_W-1:0];
            end
            if (wr || !counting) begin
                tick_cnt <= '0;         // host activity, disabled or tripped
                per_cnt  <= '0;
            end else if (tick_wrap) begin
                tick_cnt <= '0;
                per_cnt  <= per_cnt + 1'b1;
            end else begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            if (wdog_clr) begin
                wdog_timeout <= 1'b0;
            end else if (expire) begin
                wdog_timeout <= 1'b1;
            end
        end
    end

    always_comb begin
        rsp.rdata = '0;
        if (brd_sel) begin
            case (ofs)
                `QLA_OFS_STATUS: rsp.rdata = {23'd0, wdog_timeout, 4'd0, board_id};
                `QLA_OFS_TSTAMP: rsp.rdata = tstamp;
                `QLA_OFS_WDOG:   rsp.rdata = `QLA_DATA_W'(wdog_period);
                default:         rsp.rdata = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/fpga_qla_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// controller register side, wishbone port in place of firewire
// single clock domain on sysclk, encoder inputs are async
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "qla_settings.svh"

module fpga_qla_top (
    input  logic                                      sysclk,   // 49.152 MHz on the board
    input  logic                                      arst_n,
    // wishbone classic slave
    input  logic                                      cyc,
    input  logic                                      stb,
    input  logic                                      we,
    input  logic [`QLA_ADDR_W-1:0]                    adr,
    input  logic [`QLA_DATA_W-1:0]                    dat_w,
    output logic [`QLA_DATA_W-1:0]                    dat_r,
    output logic                                      ack,
    // board i/o
    input  logic [3:0]                                wenid,    // rotary switch
    input  logic [`QLA_NUM_MOTORS-1:0]                enc_a,
    input  logic [`QLA_NUM_MOTORS-1:0]                enc_b,
    output qla_pkg::motor_cmd_t [`QLA_NUM_MOTORS-1:0] motor_cmd,
    output logic                                      led
);

    qla_pkg::reg_req_t req;
    qla_pkg::reg_rsp_t rsp_chan;
    qla_pkg::reg_rsp_t rsp_board;
    logic              wdog_timeout;

    assign led = wdog_timeout;  // led lights on watchdog timeout

    reg_bus_slave u_reg_bus_slave (
        .sysclk    (sysclk),
        .arst_n    (arst_n),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .dat_r     (dat_r),
        .ack       (ack),
        .req       (req),
        .rsp_chan  (rsp_chan),
        .rsp_board (rsp_board)
    );

    motor_channels u_motor_channels (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .req          (req),
        .rsp          (rsp_chan),
        .wdog_timeout (wdog_timeout),
        .enc_a        (enc_a),
        .enc_b        (enc_b),
        .motor_cmd    (motor_cmd)
    );

    board_status u_board_status (
        .sysclk       (sysclk),
        .arst_n       (arst_n),
        .req          (req),
        .rsp          (rsp_board),
        .wenid        (wenid),
        .wdog_timeout (wdog_timeout)
    );

endmodule

`default_nettype wire

// File: tb/qla_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register and encoder model of the controller, samples on posedge
// expects one bus access at a time, ack within 8 cycles
// encoder steps are seen in the position 3 cycles later
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "qla_settings.svh"

module qla_checker (
    input  logic                                      sysclk,
    input  logic                                      arst_n,
    input  logic                                      cyc,
    input  logic                                      stb,
    input  logic                                      we,
    input  logic [`QLA_ADDR_W-1:0]                    adr,
    input  logic [`QLA_DATA_W-1:0]                    dat_w,
    input  logic [`QLA_DATA_W-1:0]                    dat_r,
    input  logic                                      ack,
    input  logic [3:0]                                wenid,
    input  logic [`QLA_NUM_MOTORS-1:0]                enc_a,
    input  logic [`QLA_NUM_MOTORS-1:0]                enc_b,
    input  qla_pkg::motor_cmd_t [`QLA_NUM_MOTORS-1:0] motor_cmd,
    input  logic                                      led,
    output int                                        data_errs,
    output int                                        bus_errs
);

    localparam int N         = `QLA_NUM_MOTORS;
    localparam int ACK_LIMIT = 8;

    logic [`QLA_CMD_W-1:0]  cmd_m   [N];
    logic                   amp_m   [N];    // enable register, unmasked
    logic [`QLA_POS_W-1:0]  pos_m   [N];
    logic [1:0]             ab_last [N];    // {a, b} at the previous edge
    int                     dly0    [N];    // step on its way through sync
    int                     dly1    [N];
    logic [`QLA_DATA_W-1:0] ts_m;
    logic [15:0]            per_m;          // watchdog period units
    logic                   to_m;           // timeout flag
    int                     idle_m;         // cycles since last write
    logic                   busy = 1'b0;
    int                     wait_n;
    logic                   acc_we;
    logic [`QLA_ADDR_W-1:0] acc_adr;
    logic [`QLA_DATA_W-1:0] acc_dat;
    logic [`QLA_DATA_W-1:0] rd_exp;
    int                     n_data = 0;
    int                     n_bus  = 0;

    assign data_errs = n_data;
    assign bus_errs  = n_bus;

    // position in the forward gray order 00 10 11 01
    function automatic int gray_index(input logic [1:0] ab);
        case (ab)
            2'b00:   return 0;
            2'b10:   return 1;
            2'b11:   return 2;
            default: return 3;
        endcase
    endfunction

    function automatic int step_of(input logic [1:0] from, input logic [1:0] to);
        int d;
        d = (gray_index(to) - gray_index(from) + 4) % 4;
        if (d == 1) return 1;
        if (d == 3) return -1;
        return 0;   // no move, or both phases at once
    endfunction

    // read word the map should give right now
    function automatic logic [`QLA_DATA_W-1:0] predict(input logic [`QLA_ADDR_W-1:0] a);
        logic [`QLA_DATA_W-1:0] word;
        int                     ch;
        word = '0;
        ch   = int'(a[7:4]) - 1;
        if (a[`QLA_ADDR_W-1:8] != '0) return word;
        if (a[7:4] == 4'd0) begin
            case (a[3:0])
                `QLA_OFS_STATUS: begin
                    word[3:0] = ~wenid;     // board id
                    word[8]   = to_m;
                end
                `QLA_OFS_TSTAMP: word = ts_m;
                `QLA_OFS_WDOG:   word[15:0] = per_m;
                default:         word = '0;
            endcase
        end else if (ch < N) begin
            case (a[3:0])
                `QLA_OFS_CMD: word = `QLA_DATA_W'(cmd_m[ch]);
                `QLA_OFS_AMP: word[0] = amp_m[ch];
                `QLA_OFS_POS: word = `QLA_DATA_W'($signed(pos_m[ch])); // sign-extended
                default:      word = '0;
            endcase
        end
        return word;
    endfunction

    task automatic apply_write(input logic [`QLA_ADDR_W-1:0] a, input logic [`QLA_DATA_W-1:0] d);
        int ch;
        ch = int'(a[7:4]) - 1;
        if (a[`QLA_ADDR_W-1:8] != '0) return;
        if (a[7:4] == 4'd0) begin
            if (a[3:0] == `QLA_OFS_WDOG) per_m <= d[15:0];
            if (a[3:0] == `QLA_OFS_STATUS && d[8]) to_m <= 1'b0;
        end else if (ch < N) begin
            case (a[3:0])
                `QLA_OFS_CMD: cmd_m[ch] <= d[`QLA_CMD_W-1:0];
                `QLA_OFS_AMP: if (!to_m) amp_m[ch] <= d[0];   // dropped in timeout
                `QLA_OFS_POS: pos_m[ch] <= d[`QLA_POS_W-1:0]; // preset beats a step
                default: ;
            endcase
        end
    endtask

    task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        $display("FAIL %s expected %h got %h at %0t", name, exp, got, $time);
        n_data++;
    endtask

    task automatic report_bus(input string what);
        $display("bus error: %s at %0t", what, $time);
        n_bus++;
    endtask

    always @(posedge sysclk or negedge arst_n) begin : edge_model
        logic [1:0] ab_now;
        logic       wr_edge;
        if (!arst_n) begin
            for (int i = 0; i < N; i++) begin
                cmd_m[i]   <= '0;
                amp_m[i]   <= 1'b0;
                pos_m[i]   <= '0;
                ab_last[i] <= 2'b00;
                dly0[i]    <= 0;
                dly1[i]    <= 0;
            end
            ts_m   <= '0;
            per_m  <= '0;
            to_m   <= 1'b0;
            idle_m <= 0;
            busy   = 1'b0;
        end else begin
            wr_edge = 1'b0;
            ts_m   <= ts_m + 1'b1;  // free-running from reset
            // outputs against the model
            for (int i = 0; i < N; i++) begin
                if (motor_cmd[i].amp_en !== (amp_m[i] && !to_m))
                    report_value($sformatf("motor_cmd[%0d].amp_en", i),
                                 32'(amp_m[i] && !to_m), 32'(motor_cmd[i].amp_en));
                if (motor_cmd[i].cur_cmd !== cmd_m[i])
                    report_value($sformatf("motor_cmd[%0d].cur_cmd", i),
                                 32'(cmd_m[i]), 32'(motor_cmd[i].cur_cmd));
            end
            if (led !== to_m) report_value("led", 32'(to_m), 32'(led));
            // encoder counts, two edges of delay then the add
            for (int i = 0; i < N; i++) begin
                ab_now      = {enc_a[i], enc_b[i]};
                ab_last[i] <= ab_now;
                dly0[i]    <= step_of(ab_last[i], ab_now);
                dly1[i]    <= dly0[i];
                pos_m[i]   <= pos_m[i] + `QLA_POS_W'(dly1[i]);
            end
            // bus cycle tracking
            if (busy) begin
                wait_n = wait_n + 1;
                if (wait_n == 1) begin      // request strobe edge
                    if (acc_we) begin
                        wr_edge = 1'b1;
                        apply_write(acc_adr, acc_dat);
                    end else begin
                        rd_exp = predict(acc_adr);
                    end
                end
                if (ack) begin
                    if (wait_n != (acc_we ? 1 : 2))
                        report_value("ack wait states", acc_we ? 32'd1 : 32'd2, 32'(wait_n));
                    if (!acc_we && dat_r !== rd_exp)
                        report_value($sformatf("dat_r at adr %h", acc_adr), rd_exp, dat_r);
                    busy = 1'b0;
                end else if (wait_n > ACK_LIMIT) begin
                    report_bus($sformatf("no ack for access to %h", acc_adr));
                    busy = 1'b0;
                end
            end else begin
                if (ack) report_bus("ack with no bus cycle open");
                if (cyc && stb) begin
                    busy    = 1'b1;
                    wait_n  = 0;
                    acc_we  = we;
                    acc_adr = adr;
                    acc_dat = dat_w;
                end
            end
            // watchdog, any write restarts it
            if (wr_edge || per_m == '0 || to_m) begin
                idle_m <= 0;
            end else begin
                if (idle_m + 1 == int'(per_m) * `QLA_WDOG_TICK) to_m <= 1'b1;
                idle_m <= idle_m + 1;
            end
            for (int i = 0; i < N; i++) begin
                if (to_m) amp_m[i] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_fpga_qla.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the controller register side
// inputs change on the falling edge, seed 63
// results are judged by qla_checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none
`timescale 1ns/10ps

`include "qla_settings.svh"

module tb_fpga_qla;

    localparam int         N            = `QLA_NUM_MOTORS;
    localparam int         CYCLE_LIMIT  = 20000;    // whole sequence is a few thousand
    localparam int         ACK_WAIT_MAX = 10;
    localparam int         WDOG_UNITS   = 4;
    localparam logic [3:0] SWITCH       = 4'b1010;  // board id 5

    logic                        sysclk;
    logic                        arst_n;
    logic                        cyc;
    logic                        stb;
    logic                        we;
    logic [`QLA_ADDR_W-1:0]      adr;
    logic [`QLA_DATA_W-1:0]      dat_w;
    logic [`QLA_DATA_W-1:0]      dat_r;
    logic                        ack;
    logic [3:0]                  wenid;
    logic [N-1:0]                enc_a;
    logic [N-1:0]                enc_b;
    qla_pkg::motor_cmd_t [N-1:0] motor_cmd;
    logic                        led;
    int                          data_errs;
    int                          bus_errs;
    integer                      seed = 63;
    int                          cycle_cnt = 0;
    int                          gidx [N];  // gray state per channel

    fpga_qla_top u_fpga_qla_top (
        .sysclk (sysclk), .arst_n (arst_n),
        .cyc (cyc), .stb (stb), .we (we), .adr (adr), .dat_w (dat_w),
        .dat_r (dat_r), .ack (ack),
        .wenid (wenid), .enc_a (enc_a), .enc_b (enc_b),
        .motor_cmd (motor_cmd), .led (led)
    );

    qla_checker u_qla_checker (
        .sysclk (sysclk), .arst_n (arst_n),
        .cyc (cyc), .stb (stb), .we (we), .adr (adr), .dat_w (dat_w),
        .dat_r (dat_r), .ack (ack),
        .wenid (wenid), .enc_a (enc_a), .enc_b (enc_b),
        .motor_cmd (motor_cmd), .led (led),
        .data_errs (data_errs), .bus_errs (bus_errs)
    );

    initial begin
        sysclk = 1'b0;
        forever #5 sysclk = ~sysclk;
    end

    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("timeout: sequence still running after %0d cycles", CYCLE_LIMIT);
            $display("closing: %0d data errors, %0d bus errors", data_errs, bus_errs);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [`QLA_ADDR_W-1:0] addr_of(input int blk, input logic [3:0] ofs);
        return {8'h00, 4'(blk), ofs};
    endfunction

    // somewhere no register lives
    function automatic logic [`QLA_ADDR_W-1:0] unmapped_addr();
        int kind;
        kind = rand_below(3);
        if (kind == 0) return addr_of(N + 1 + rand_below(15 - N), 4'(rand_below(16)));
        if (kind == 1) return addr_of(rand_below(N + 1), 4'(3 + rand_below(13)));
        return {8'(1 + rand_below(255)), 8'(rand_below(256))};   // upper byte set
    endfunction

    function automatic logic [1:0] gray_code(input int idx);
        case (idx)
            0:       return 2'b00;
            1:       return 2'b10;  // a leads on forward
            2:       return 2'b11;
            default: return 2'b01;
        endcase
    endfunction

    task automatic idle(input int n);
        repeat (n) @(negedge sysclk);
    endtask

    // one classic cycle, then stb low long enough for the slave to reach idle
    task automatic bus_access(input logic w, input logic [`QLA_ADDR_W-1:0] a,
                              input logic [`QLA_DATA_W-1:0] d);
        int n;
        n     = 0;
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = w;
        adr   = a;
        dat_w = d;
        do begin
            @(negedge sysclk);
            n++;
        end while (!ack && n < ACK_WAIT_MAX);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        idle(3);
    endtask

    task automatic bus_write(input logic [`QLA_ADDR_W-1:0] a, input logic [`QLA_DATA_W-1:0] d);
        bus_access(1'b1, a, d);
    endtask

    task automatic bus_read(input logic [`QLA_ADDR_W-1:0] a);
        bus_access(1'b0, a, '0);
    endtask

    task automatic read_channels(input logic [3:0] ofs);
        for (int ch = 1; ch <= N; ch++) bus_read(addr_of(ch, ofs));
    endtask

    // every channel takes one random gray step, then holds 4 to 7 cycles
    task automatic step_encoders(input int nsteps);
        logic [1:0] ab;
        for (int s = 0; s < nsteps; s++) begin
            for (int i = 0; i < N; i++) begin
                gidx[i]  = (rand_below(2) == 1) ? (gidx[i] + 1) % 4 : (gidx[i] + 3) % 4;
                ab       = gray_code(gidx[i]);
                enc_a[i] = ab[1];
                enc_b[i] = ab[0];
            end
            idle(4 + rand_below(4));
        end
    endtask

    initial begin
        logic [`QLA_ADDR_W-1:0] a;
        int                     ch;
        cyc    = 1'b0;
        stb    = 1'b0;
        we     = 1'b0;
        adr    = '0;
        dat_w  = '0;
        wenid  = SWITCH;
        enc_a  = '0;
        enc_b  = '0;
        arst_n = 1'b0;
        for (int i = 0; i < N; i++) gidx[i] = 0;
        repeat (4) @(negedge sysclk);
        arst_n = 1'b1;
        idle(2);
        // reset values
        bus_read(addr_of(0, `QLA_OFS_STATUS));
        bus_read(addr_of(0, `QLA_OFS_WDOG));
        read_channels(`QLA_OFS_CMD);
        read_channels(`QLA_OFS_AMP);
        read_channels(`QLA_OFS_POS);
        // random command and enable traffic
        repeat (40) begin
            ch = 1 + rand_below(N);
            a  = addr_of(ch, (rand_below(2) == 1) ? `QLA_OFS_CMD : `QLA_OFS_AMP);
            bus_write(a, (a[3:0] == `QLA_OFS_CMD) ? $random(seed) : 32'(rand_below(2)));
            bus_read(a);
        end
        repeat (15) begin
            a = unmapped_addr();
            bus_write(a, $random(seed));
            bus_read(a);
        end
        read_channels(`QLA_OFS_CMD);
        read_channels(`QLA_OFS_AMP);
        // timestamp, two reads a random gap apart
        bus_read(addr_of(0, `QLA_OFS_TSTAMP));
        idle(1 + rand_below(20));
        bus_read(addr_of(0, `QLA_OFS_TSTAMP));
        // encoders, then preset and continue
        step_encoders(60);
        idle(4);
        read_channels(`QLA_OFS_POS);
        for (ch = 1; ch <= N; ch++) bus_write(addr_of(ch, `QLA_OFS_POS), $random(seed));
        read_channels(`QLA_OFS_POS);
        step_encoders(30);
        idle(4);
        read_channels(`QLA_OFS_POS);
        // watchdog kept alive by writes well inside the period
        bus_write(addr_of(0, `QLA_OFS_WDOG), 32'(WDOG_UNITS));
        for (ch = 1; ch <= N; ch++) bus_write(addr_of(ch, `QLA_OFS_AMP), 32'd1);
        repeat (10) begin
            bus_write(addr_of(1 + rand_below(N), `QLA_OFS_CMD), $random(seed));
            idle(20);
        end
        bus_read(addr_of(0, `QLA_OFS_STATUS));
        // now let it trip
        idle(WDOG_UNITS * `QLA_WDOG_TICK + 15);
        bus_read(addr_of(0, `QLA_OFS_STATUS));
        read_channels(`QLA_OFS_AMP);
        bus_write(addr_of(1, `QLA_OFS_AMP), 32'd1);   // ignored while tripped
        bus_read(addr_of(1, `QLA_OFS_AMP));
        bus_write(addr_of(0, `QLA_OFS_STATUS), 32'h100);
        bus_write(addr_of(0, `QLA_OFS_WDOG), 32'd0);
        for (ch = 1; ch <= N; ch++) bus_write(addr_of(ch, `QLA_OFS_AMP), 32'd1);
        read_channels(`QLA_OFS_AMP);
        bus_read(addr_of(0, `QLA_OFS_STATUS));
        idle(4);
        $display("closing: %0d data errors, %0d bus errors", data_errs, bus_errs);
        if (data_errs + bus_errs == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+logic
logic/qla_pkg.sv
logic/reg_bus_slave.sv
logic/quad_encoder.sv
logic/motor_channels.sv
logic/board_status.sv
logic/fpga_qla_top.sv
tb/qla_checker.sv
tb/tb_fpga_qla.sv

// File: Makefile
# Verilator build for the motor controller register side
TOP := tb_fpga_qla

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing -f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
